//--- list.f
+incdir+src
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_receiver.sv
src/uart_transmitter.sv
src/rx_fifo.sv
src/uart_top.sv
testbench/tb_uart_top.sv

//--- Bender.yml
package:
  name: uart_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/uart_pkg.sv
      - src/baud_tick_gen.sv
      - src/uart_receiver.sv
      - src/uart_transmitter.sv
      - src/rx_fifo.sv
      - src/uart_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_uart_top.sv

//--- testbench/tb_uart_top.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module tb_uart_top;

    localparam int clk_period  = 40;
    localparam int bit_clks    = `UART_TICKS_PER_BIT * `UART_CLKS_PER_TICK;
    localparam int frame_clks  = (`UART_DATA_BITS + 2) * bit_clks;  // Start, data, stop
    localparam int watchdog_ns = (14 * frame_clks + 4 * bit_clks) * clk_period;
    localparam int tx_count    = 3;

    logic                clk = 1'b0;
    logic                reset;
    logic                rx_line;
    logic                tx_start;
    logic                rx_pop;
    byte                 tx_data;
    logic                tx_line;
    logic                tx_busy;
    logic                rx_empty;
    logic                rx_overflow;
    uart_pkg::rx_frame_t rx_frame;

    integer              seed           = 32'h8ed98d83;
    int                  rx_err_cnt     = 0;
    int                  tx_err_cnt     = 0;
    int                  tx_frames_seen = 0;
    logic                exp_overflow   = 1'b0;  // Model FIFO has dropped a frame
    logic                glitch_watch   = 1'b0;
    logic                tx_in_frame    = 1'b0;
    uart_pkg::rx_frame_t exp_rx_q [$];
    logic [7:0]          exp_tx_q [$];

    always #(clk_period / 2) clk = ~clk;

    uart_top dut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_rx          (rx_line),
        .i_tx_start    (tx_start),
        .i_rx_pop      (rx_pop),
        .i_tx_data     (tx_data),
        .o_tx          (tx_line),
        .o_tx_busy     (tx_busy),
        .o_rx_empty    (rx_empty),
        .o_rx_overflow (rx_overflow),
        .o_rx_frame    (rx_frame)
    );

    task automatic rx_mismatch(input string msg);
        rx_err_cnt++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    task automatic tx_mismatch(input string msg);
        tx_err_cnt++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    function automatic logic [7:0] random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Returns 1 ns after the rising edge, where inputs change
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    a_no_glitch_frame: assert property (@(posedge clk) disable iff (reset)
        glitch_watch |-> rx_empty)
        else rx_mismatch("FIFO took a frame from a short low pulse");

    a_no_early_overflow: assert property (@(posedge clk) disable iff (reset)
        !exp_overflow |-> !rx_overflow)
        else rx_mismatch("o_rx_overflow set while the FIFO had room");

    a_busy_in_frame: assert property (@(posedge clk) disable iff (reset)
        tx_in_frame |-> tx_busy)
        else tx_mismatch("o_tx_busy low inside a transmitted frame");

    // Serial model of a remote transmitter, 8N1
    task automatic serial_send(input logic [7:0] data, input logic bad_stop);
        uart_pkg::rx_frame_t exp;
        exp.data        = data;
        exp.framing_err = bad_stop;
        if (exp_rx_q.size() < `UART_FIFO_DEPTH) begin
            exp_rx_q.push_back(exp);
        end else begin
            exp_overflow = 1'b1;  // Frame will be dropped
        end
        rx_line = 1'b0;
        repeat (bit_clks) next_cycle();
        for (int i = 0; i < `UART_DATA_BITS; i++) begin
            rx_line = data[i];  // LSB first
            repeat (bit_clks) next_cycle();
        end
        if (bad_stop) begin
            // High again before the receiver could take the low tail as a new start bit
            rx_line = 1'b0;
            repeat (bit_clks * 3 / 4) next_cycle();
            rx_line = 1'b1;
            repeat (bit_clks / 4) next_cycle();
        end else begin
            rx_line = 1'b1;
            repeat (bit_clks) next_cycle();
        end
    endtask

    task automatic pop_and_compare();
        uart_pkg::rx_frame_t exp;
        int                  waited;
        waited = 0;
        while (rx_empty && waited < bit_clks) begin
            next_cycle();
            waited++;
        end
        if (rx_empty) begin
            rx_err_cnt++;
            $display("Error at %0d ns: receive FIFO stayed empty, frame never arrived", $time);
        end else if (exp_rx_q.size() == 0) begin
            rx_err_cnt++;
            $display("Error at %0d ns: receive FIFO holds a frame that was never sent", $time);
        end else begin
            exp = exp_rx_q.pop_front();
            a_head: assert (rx_frame == exp)
                else rx_mismatch($sformatf("head data %h ferr %b, expected data %h ferr %b",
                    rx_frame.data, rx_frame.framing_err, exp.data, exp.framing_err));
            rx_pop = 1'b1;
            next_cycle();
            rx_pop = 1'b0;
            a_empty_after_pop: assert (rx_empty == (exp_rx_q.size() == 0))
                else rx_mismatch($sformatf("o_rx_empty %b after pop", rx_empty));
        end
    endtask

    task automatic tx_send(input logic [7:0] data);
        int waited;
        exp_tx_q.push_back(data);
        tx_data  = data;
        tx_start = 1'b1;
        next_cycle();
        tx_start = 1'b0;
        a_busy_rise: assert (tx_busy)
            else tx_mismatch("o_tx_busy did not rise after the start strobe");
        repeat (frame_clks / 2) next_cycle();
        tx_data  = ~data;  // Must not reach the line
        tx_start = 1'b1;
        next_cycle();
        tx_start = 1'b0;
        waited = 0;
        while (tx_busy && waited < frame_clks) begin
            next_cycle();
            waited++;
        end
        if (tx_busy) begin
            tx_err_cnt++;
            $display("Error at %0d ns: transmitter stayed busy past one frame", $time);
        end
    endtask

    // Decodes o_tx at mid-bit, sampled on the falling clock edge
    initial begin : tx_monitor
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(negedge clk);
            if (!reset && tx_line === 1'b0) begin
                tx_in_frame = 1'b1;
                repeat (bit_clks / 2) @(negedge clk);
                a_start_low: assert (tx_line == 1'b0)
                    else tx_mismatch("start bit on o_tx not low at mid-bit");
                for (int i = 0; i < `UART_DATA_BITS; i++) begin
                    repeat (bit_clks) @(negedge clk);
                    got[i] = tx_line;
                end
                repeat (bit_clks) @(negedge clk);
                a_stop_high: assert (tx_line == 1'b1)
                    else tx_mismatch("stop bit on o_tx not high at mid-bit");
                tx_in_frame = 1'b0;
                tx_frames_seen++;
                if (exp_tx_q.size() == 0) begin
                    tx_err_cnt++;
                    $display("Error at %0d ns: frame on o_tx that was never requested", $time);
                end else begin
                    exp = exp_tx_q.pop_front();
                    a_tx_byte: assert (got == exp)
                        else tx_mismatch($sformatf("o_tx carried %h, expected %h", got, exp));
                end
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout: simulation still running after %0d ns", watchdog_ns);
        $display("Some tests failed");
        $finish;
    end

    initial begin : stimulus
        logic [7:0] d;
        reset    = 1'b1;
        rx_line  = 1'b1;
        tx_start = 1'b0;
        rx_pop   = 1'b0;
        tx_data  = '0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        // Idle levels after reset
        a_rst_tx: assert (tx_line == 1'b1) else tx_mismatch("o_tx not high after reset");
        a_rst_busy: assert (!tx_busy) else tx_mismatch("o_tx_busy high after reset");
        a_rst_empty: assert (rx_empty) else rx_mismatch("o_rx_empty low after reset");
        a_rst_ovf: assert (!rx_overflow) else rx_mismatch("o_rx_overflow high after reset");

        d = random_byte();
        serial_send(d, 1'b0);
        pop_and_compare();

        d = random_byte();
        serial_send(d, 1'b1);  // Low stop bit
        pop_and_compare();

        // Low pulse of a quarter bit
        glitch_watch = 1'b1;
        rx_line      = 1'b0;
        repeat (bit_clks / 4) next_cycle();
        rx_line = 1'b1;
        repeat (frame_clks) next_cycle();
        glitch_watch = 1'b0;

        // One frame more than the FIFO holds
        repeat (`UART_FIFO_DEPTH + 1) serial_send(random_byte(), 1'b0);
        a_ovf_set: assert (rx_overflow == exp_overflow)
            else rx_mismatch("o_rx_overflow not set after a write to a full FIFO");
        repeat (`UART_FIFO_DEPTH) pop_and_compare();
        a_ovf_sticky: assert (rx_overflow)
            else rx_mismatch("o_rx_overflow cleared by pops");

        repeat (tx_count) tx_send(random_byte());
        next_cycle();
        a_tx_all_seen: assert (exp_tx_q.size() == 0 && tx_frames_seen == tx_count)
            else tx_mismatch($sformatf("%0d frames decoded on o_tx, %0d requested",
                tx_frames_seen, tx_count));

        $display("Errors: %0d receive, %0d transmit", rx_err_cnt, tx_err_cnt);
        if (rx_err_cnt + tx_err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- src/uart_top.sv
`timescale 1ns/10ps

module uart_top (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rx,
    input  logic                i_tx_start,
    input  logic                i_rx_pop,
    input  byte                 i_tx_data,
    output logic                o_tx,
    output logic                o_tx_busy,
    output logic                o_rx_empty,
    output logic                o_rx_overflow,
    output uart_pkg::rx_frame_t o_rx_frame
);

    logic                tick;      // Shared by RX and TX
    logic                rx_done;
    uart_pkg::rx_frame_t rx_frame;

    baud_tick_gen u_tick_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_receiver u_rx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .i_tick  (tick),
        .o_done  (rx_done),
        .o_frame (rx_frame)
    );

    // No back-pressure, a full FIFO loses frames
    rx_fifo u_rx_fifo (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_write    (rx_done),
        .i_pop      (i_rx_pop),
        .i_frame    (rx_frame),
        .o_frame    (o_rx_frame),
        .o_empty    (o_rx_empty),
        .o_overflow (o_rx_overflow)
    );

    uart_transmitter u_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (i_tx_start),
        .i_tick  (tick),
        .i_data  (i_tx_data),
        .o_tx    (o_tx),
        .o_busy  (o_tx_busy)
    );

endmodule

//--- src/rx_fifo.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module rx_fifo (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_write,
    input  logic                i_pop,
    input  uart_pkg::rx_frame_t i_frame,
    output uart_pkg::rx_frame_t o_frame,
    output logic                o_empty,
    output logic                o_overflow
);

    localparam int ptr_w = $clog2(`UART_FIFO_DEPTH);
    localparam int cnt_w = $clog2(`UART_FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(`UART_FIFO_DEPTH - 1);
    localparam logic [cnt_w-1:0] depth     = cnt_w'(`UART_FIFO_DEPTH);

    uart_pkg::rx_frame_t mem [`UART_FIFO_DEPTH];
    logic [ptr_w-1:0]    wr_ptr, rd_ptr;
    logic [cnt_w-1:0]    count;
    logic                full;
    logic                do_write;
    logic                do_pop;

    assign full     = (count == depth);
    assign o_empty  = (count == '0);
    assign do_write = i_write && !full;   // Frame dropped when full
    assign do_pop   = i_pop && !o_empty;  // Pop on empty ignored

    always_ff @(posedge i_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= i_frame;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (i_write && full) begin
                o_overflow <= 1'b1;  // Sticky until reset
            end
        end
    end

    assign o_frame = mem[rd_ptr];  // Fall-through head

    a_count_bound: assert property (@(posedge i_clk) disable iff (i_reset)
        count <= depth)
        else $error("fifo count above depth");

endmodule

//--- src/uart_transmitter.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_transmitter (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_start,
    input  logic                       i_tick,
    input  logic [`UART_DATA_BITS-1:0] i_data,
    output logic                       o_tx,
    output logic                       o_busy
);

    localparam int tick_w = $clog2(`UART_TICKS_PER_BIT);
    localparam int bit_w  = $clog2(`UART_DATA_BITS);
    localparam logic [tick_w-1:0] last_tick = tick_w'(`UART_TICKS_PER_BIT - 1);
    localparam logic [bit_w-1:0]  last_bit  = bit_w'(`UART_DATA_BITS - 1);

    uart_pkg::tx_state_e        state, next_state;
    logic [tick_w-1:0]          tick_cnt, next_tick_cnt;
    logic [bit_w-1:0]           bit_cnt, next_bit_cnt;
    logic [`UART_DATA_BITS-1:0] shift_reg, next_shift_reg;
    logic                       tx_reg, next_tx;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= uart_pkg::tx_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_reg   <= 1'b1;  // Line idles high
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
            tx_reg   <= next_tx;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift_reg;
    end

    always_comb begin
        next_state     = state;
        next_tick_cnt  = tick_cnt;
        next_bit_cnt   = bit_cnt;
        next_shift_reg = shift_reg;

        case (state)
            uart_pkg::tx_idle: begin
                if (i_start) begin
                    next_state     = uart_pkg::tx_start;
                    next_tick_cnt  = '0;
                    next_shift_reg = i_data;
                end
            end

            uart_pkg::tx_start: begin
                if (i_tick) begin
                    if (tick_cnt == last_tick) begin
                        next_state    = uart_pkg::tx_data;
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::tx_data: begin
                if (i_tick) begin
                    if (tick_cnt == last_tick) begin
                        next_tick_cnt  = '0;
                        next_shift_reg = shift_reg >> 1;
                        if (bit_cnt == last_bit) begin
                            next_state = uart_pkg::tx_stop;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::tx_stop: begin
                if (i_tick) begin
                    if (tick_cnt == last_tick) begin
                        next_state = uart_pkg::tx_idle;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            default: next_state = uart_pkg::tx_idle;
        endcase

        // Line level follows the state it will be in, so tx_reg and state stay aligned
        case (next_state)
            uart_pkg::tx_start: next_tx = 1'b0;
            uart_pkg::tx_data:  next_tx = next_shift_reg[0];
            default:            next_tx = 1'b1;
        endcase
    end

    assign o_tx   = tx_reg;
    assign o_busy = (state != uart_pkg::tx_idle);

    a_idle_high: assert property (@(posedge i_clk) disable iff (i_reset)
        !o_busy |-> o_tx)
        else $error("tx line low while not busy");

endmodule

//--- src/uart_receiver.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module uart_receiver (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rx,
    input  logic                i_tick,
    output logic                o_done,
    output uart_pkg::rx_frame_t o_frame
);

    localparam int tick_w = $clog2(`UART_TICKS_PER_BIT);
    localparam int bit_w  = $clog2(`UART_DATA_BITS);
    localparam logic [tick_w-1:0] mid_tick  = tick_w'(`UART_TICKS_PER_BIT / 2 - 1);
    localparam logic [tick_w-1:0] last_tick = tick_w'(`UART_TICKS_PER_BIT - 1);
    localparam logic [bit_w-1:0]  last_bit  = bit_w'(`UART_DATA_BITS - 1);

    uart_pkg::rx_state_e        state, next_state;
    logic [tick_w-1:0]          tick_cnt, next_tick_cnt;
    logic [bit_w-1:0]           bit_cnt, next_bit_cnt;
    logic [`UART_DATA_BITS-1:0] shift_reg, next_shift_reg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= uart_pkg::rx_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift_reg;
    end

    always_comb begin
        next_state     = state;
        next_tick_cnt  = tick_cnt;
        next_bit_cnt   = bit_cnt;
        next_shift_reg = shift_reg;
        o_done         = 1'b0;

        case (state)
            uart_pkg::rx_idle: begin
                if (!i_rx) begin  // Falling edge, possible start bit
                    next_state    = uart_pkg::rx_start;
                    next_tick_cnt = '0;
                end
            end

            uart_pkg::rx_start: begin
                if (i_tick) begin
                    if (tick_cnt == mid_tick) begin
                        next_tick_cnt = '0;
                        if (i_rx) begin
                            next_state = uart_pkg::rx_idle;  // Glitch, not a real start bit
                        end else begin
                            next_state   = uart_pkg::rx_data;
                            next_bit_cnt = '0;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::rx_data: begin
                if (i_tick) begin
                    if (tick_cnt == last_tick) begin
                        next_tick_cnt  = '0;
                        next_shift_reg = {i_rx, shift_reg[`UART_DATA_BITS-1:1]};  // LSB first
                        if (bit_cnt == last_bit) begin
                            next_state = uart_pkg::rx_stop;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::rx_stop: begin
                if (i_tick) begin
                    if (tick_cnt == last_tick) begin  // Middle of stop bit
                        next_state = uart_pkg::rx_idle;
                        o_done     = 1'b1;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            default: next_state = uart_pkg::rx_idle;
        endcase
    end

    // Stop bit is taken live, valid together with o_done
    assign o_frame.data        = shift_reg;
    assign o_frame.framing_err = ~i_rx;

    a_done_in_stop: assert property (@(posedge i_clk) disable iff (i_reset)
        o_done |-> (state == uart_pkg::rx_stop))
        else $error("rx done pulse outside stop state");

endmodule

//--- src/baud_tick_gen.sv
`timescale 1ns/10ps
`include "uart_macros.svh"

module baud_tick_gen (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    localparam int cnt_w = $clog2(`UART_CLKS_PER_TICK);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`UART_CLKS_PER_TICK - 1);

    logic [cnt_w-1:0] cnt;

    // Free running modulo counter
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (cnt == last_cnt) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_tick = (cnt == last_cnt);  // One clock at wrap

endmodule

//--- src/uart_pkg.sv
`include "uart_macros.svh"

package uart_pkg;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,  // Waiting for mid start bit
        rx_data,
        rx_stop
    } rx_state_e;

    // Transmitter FSM
    typedef enum logic [1:0] {
        tx_idle,
        tx_start,
        tx_data,
        tx_stop
    } tx_state_e;

    // One received character as stored in the FIFO
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       framing_err;  // Stop bit was low
    } rx_frame_t;

endpackage

//--- src/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Frame format, 8N1
`define UART_DATA_BITS 8

// Oversampling ticks in one bit period
`define UART_TICKS_PER_BIT 16

// System clocks between two baud ticks
// One bit is UART_TICKS_PER_BIT * UART_CLKS_PER_TICK clocks
`define UART_CLKS_PER_TICK 4

// Receive FIFO entries
`define UART_FIFO_DEPTH 4

`endif
